/* mem_pipe.f */
rtl/mem_pipe_pkg.sv
rtl/mem_agu.sv
rtl/mem_req_queue.sv
rtl/mem_data_stage.sv
rtl/mem_pipe.sv
tests/mem_pipe_checker.sv
tests/mem_pipe_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       := mem_pipe_tb
FILELIST  := mem_pipe.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "No verdict found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/mem_pipe_tb.sv */
/*
 * Testbench for the load/store pipe.
 * Drives directed and seeded random instructions into mem_pipe and
 * checks every result against a byte-level memory model kept here.
 * Ends with a summary line and the overall verdict.
 */

`timescale 1ns/1ps

module mem_pipe_tb;

  localparam int MEM_WORDS   = 64;
  localparam int QUEUE_DEPTH = 4;
  localparam int MEM_BYTES   = MEM_WORDS * 8;
  localparam int N_BASIC     = 32;
  localparam int N_MISALIGN  = 9;
  localparam int N_RANGE     = 8;
  localparam int N_STALL     = QUEUE_DEPTH + 1;
  localparam int N_RANDOM    = 300;
  localparam int N_TOTAL     = N_BASIC + N_MISALIGN + N_RANGE + N_STALL + N_RANDOM;
  localparam int CYCLE_LIMIT = 20 * N_TOTAL + 200;

  logic                        clk;
  logic                        rst_n;
  logic                        in_v;
  logic                        in_ready;
  mem_pipe_pkg::mem_op_e       in_op;
  logic [4:0]                  in_rd;
  logic [63:0]                 in_rs1;
  logic [63:0]                 in_imm;
  logic [63:0]                 in_rs2;
  logic                        out_v;
  logic                        out_ready;
  logic [4:0]                  out_rd;
  logic [63:0]                 out_data;
  mem_pipe_pkg::mem_fault_e    out_fault;

  logic [7:0]                  model_mem [MEM_BYTES];
  logic [4:0]                  exp_rd [$];
  logic [63:0]                 exp_data [$];
  mem_pipe_pkg::mem_fault_e    exp_fault [$];

  int  errors;
  int  checks;
  int  test_err_base;
  int  cycles;
  bit  rand_ready;

  mem_pipe_pkg::mem_op_e load_ops [7] = '{mem_pipe_pkg::e_op_lb, mem_pipe_pkg::e_op_lh,
    mem_pipe_pkg::e_op_lw, mem_pipe_pkg::e_op_ld, mem_pipe_pkg::e_op_lbu,
    mem_pipe_pkg::e_op_lhu, mem_pipe_pkg::e_op_lwu};
  mem_pipe_pkg::mem_op_e store_ops [4] = '{mem_pipe_pkg::e_op_sb, mem_pipe_pkg::e_op_sh,
    mem_pipe_pkg::e_op_sw, mem_pipe_pkg::e_op_sd};

  mem_pipe #(
    .MEM_WORDS   (MEM_WORDS),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_v_i      (in_v),
    .in_ready_o  (in_ready),
    .in_op_i     (in_op),
    .in_rd_i     (in_rd),
    .in_rs1_i    (in_rs1),
    .in_imm_i    (in_imm),
    .in_rs2_i    (in_rs2),
    .out_v_o     (out_v),
    .out_ready_i (out_ready),
    .out_rd_o    (out_rd),
    .out_data_o  (out_data),
    .out_fault_o (out_fault)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic int size_bytes(mem_pipe_pkg::mem_op_e op);
    case (op)
      mem_pipe_pkg::e_op_lb, mem_pipe_pkg::e_op_lbu, mem_pipe_pkg::e_op_sb: return 1;
      mem_pipe_pkg::e_op_lh, mem_pipe_pkg::e_op_lhu, mem_pipe_pkg::e_op_sh: return 2;
      mem_pipe_pkg::e_op_lw, mem_pipe_pkg::e_op_lwu, mem_pipe_pkg::e_op_sw: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic bit writes_memory(mem_pipe_pkg::mem_op_e op);
    return op inside {mem_pipe_pkg::e_op_sb, mem_pipe_pkg::e_op_sh,
                      mem_pipe_pkg::e_op_sw, mem_pipe_pkg::e_op_sd};
  endfunction

  function automatic bit zero_extends(mem_pipe_pkg::mem_op_e op);
    return op inside {mem_pipe_pkg::e_op_lbu, mem_pipe_pkg::e_op_lhu, mem_pipe_pkg::e_op_lwu};
  endfunction

  // Apply one accepted instruction to the model, in acceptance order
  task automatic model_accept(input mem_pipe_pkg::mem_op_e op, input logic [4:0] rd,
                              input logic [63:0] rs1, input logic [63:0] imm,
                              input logic [63:0] rs2);
    logic [63:0]              addr;
    logic [63:0]              value;
    int                       nbytes;
    int                       idx;
    mem_pipe_pkg::mem_fault_e fault;
    addr   = rs1 + imm;
    nbytes = size_bytes(op);
    value  = '0;
    if ((addr & 64'(nbytes - 1)) != 64'd0)
      fault = mem_pipe_pkg::e_fault_misaligned;
    else if (addr >= 64'(MEM_BYTES))
      fault = mem_pipe_pkg::e_fault_access;
    else
      fault = mem_pipe_pkg::e_fault_none;
    if (fault == mem_pipe_pkg::e_fault_none && writes_memory(op))
    begin
      for (int b = 0; b < nbytes; b++)
      begin
        idx = int'(addr[8:0]) + b;
        model_mem[idx] = rs2[8*b +: 8];
      end
      return;
    end
    if (fault == mem_pipe_pkg::e_fault_none)
    begin
      for (int b = 0; b < nbytes; b++)
      begin
        idx = int'(addr[8:0]) + b;
        value[8*b +: 8] = model_mem[idx];
      end
      if (!zero_extends(op) && nbytes < 8 && value[8*nbytes-1])
        value = value | (~64'd0 << (8 * nbytes));
    end
    exp_rd.push_back(rd);
    exp_data.push_back(value);
    exp_fault.push_back(fault);
  endtask

  task automatic check_result();
    logic [4:0]               e_rd;
    logic [63:0]              e_data;
    mem_pipe_pkg::mem_fault_e e_fault;
    if (exp_rd.size() == 0)
    begin
      errors++;
      $display("Unexpected result for rd %0d at %0t with nothing outstanding", out_rd, $time);
      return;
    end
    e_rd    = exp_rd.pop_front();
    e_data  = exp_data.pop_front();
    e_fault = exp_fault.pop_front();
    checks++;
    if (out_rd !== e_rd)
    begin
      errors++;
      $display("ERR %0t: rd expected %0d, got %0d", $time, e_rd, out_rd);
    end
    if (out_fault !== e_fault)
    begin
      errors++;
      $display("ERR %0t: fault expected %s, got %0d", $time, e_fault.name(), out_fault);
    end
    if (out_data !== e_data)
    begin
      errors++;
      $display("ERR %0t: data expected %h, got %h", $time, e_data, out_data);
    end
  endtask

  // Handshakes are sampled mid-cycle, away from the driving edge
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (out_v && out_ready)
        check_result();
      if (in_v && in_ready)
        model_accept(in_op, in_rd, in_rs1, in_imm, in_rs2);
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
    if (rand_ready)
      out_ready = 1'($urandom_range(0, 1));
  endtask

  task automatic send_at(input mem_pipe_pkg::mem_op_e op, input logic [4:0] rd,
                         input logic [63:0] addr, input logic [63:0] data);
    int          off;
    logic [63:0] imm;
    off    = int'($urandom_range(0, 63)) - 32;
    imm    = 64'(off);
    in_v   = 1'b1;
    in_op  = op;
    in_rd  = rd;
    in_rs1 = addr - imm;
    in_imm = imm;
    in_rs2 = data;
    while (!in_ready)
      step();
    step();
    in_v = 1'b0;
  endtask

  task automatic drain();
    rand_ready = 1'b0;
    out_ready  = 1'b1;
    while (exp_rd.size() != 0 || out_v)
      step();
  endtask

  task automatic finish_test(input string name);
    $display("%s: done, %0d errors", name, errors - test_err_base);
    test_err_base = errors;
  endtask

  task automatic run_basic();
    for (int k = 0; k < 4; k++)
      send_at(store_ops[k], 5'd0, 64'h100 + 64'(8 * k),
              {$urandom, $urandom} | 64'h8080_8080_8080_8080);
    for (int k = 0; k < 4; k++)
      for (int j = 0; j < 7; j++)
        send_at(load_ops[j], 5'(k * 7 + j + 1), 64'h100 + 64'(8 * k), 64'd0);
    drain();
  endtask

  task automatic run_misaligned();
    send_at(mem_pipe_pkg::e_op_sh, 5'd10, 64'h101, 64'hdead_beef_dead_beef);
    send_at(mem_pipe_pkg::e_op_sw, 5'd11, 64'h10a, 64'hdead_beef_dead_beef);
    send_at(mem_pipe_pkg::e_op_sd, 5'd12, 64'h114, 64'hdead_beef_dead_beef);
    send_at(mem_pipe_pkg::e_op_lh, 5'd1, 64'h103, 64'd0);
    send_at(mem_pipe_pkg::e_op_lw, 5'd2, 64'h106, 64'd0);
    send_at(mem_pipe_pkg::e_op_ld, 5'd3, 64'h11c, 64'd0);
    for (int k = 0; k < 3; k++)
      send_at(mem_pipe_pkg::e_op_ld, 5'(4 + k), 64'h100 + 64'(8 * k), 64'd0);
    drain();
  endtask

  task automatic run_out_of_range();
    // Words 0 and 11 are where the faulting stores would alias
    send_at(mem_pipe_pkg::e_op_sd, 5'd0, 64'h000, {$urandom, $urandom});
    send_at(mem_pipe_pkg::e_op_sd, 5'd0, 64'h058, {$urandom, $urandom});
    send_at(mem_pipe_pkg::e_op_sd, 5'd20, 64'h200, 64'hffff_ffff_ffff_ffff);
    send_at(mem_pipe_pkg::e_op_sb, 5'd21, 64'h258, 64'hffff_ffff_ffff_ffff);
    send_at(mem_pipe_pkg::e_op_ld, 5'd22, 64'h400, 64'd0);
    send_at(mem_pipe_pkg::e_op_lw, 5'd23, 64'hffff_ffff_ffff_fff8, 64'd0);
    send_at(mem_pipe_pkg::e_op_ld, 5'd24, 64'h000, 64'd0);
    send_at(mem_pipe_pkg::e_op_ld, 5'd25, 64'h058, 64'd0);
    drain();
  endtask

  task automatic run_stall();
    int accepted;
    accepted   = 0;
    rand_ready = 1'b0;
    out_ready  = 1'b0;
    in_v       = 1'b1;
    in_op      = mem_pipe_pkg::e_op_ld;
    in_rd      = 5'd1;
    in_rs1     = 64'h100;
    in_imm     = 64'd0;
    repeat (20)
    begin
      if (in_ready)
        accepted++;
      step();
      in_rd  = 5'(accepted + 1);
      in_rs1 = 64'h100 + 64'(8 * accepted);
    end
    in_v = 1'b0;
    if (accepted != N_STALL)
    begin
      errors++;
      $display("ERR %0t: stalled pipe accepted %0d loads, expected %0d",
               $time, accepted, N_STALL);
    end
    drain();
  endtask

  task automatic run_random();
    mem_pipe_pkg::mem_op_e op;
    logic [63:0]           addr;
    int                    pick;
    int                    gap;
    rand_ready = 1'b1;
    for (int i = 0; i < N_RANDOM; i++)
    begin
      gap = int'($urandom_range(0, 2));
      repeat (gap)
        step();
      pick = int'($urandom_range(0, 10));
      op   = (pick < 7) ? load_ops[pick] : store_ops[pick - 7];
      pick = int'($urandom_range(0, 9));
      // Mostly aligned hits in a small window so loads see earlier stores
      if (pick < 6)
        addr = 64'($urandom_range(0, 127)) & ~64'(size_bytes(op) - 1);
      else if (pick == 6)
        addr = 64'($urandom_range(0, MEM_BYTES - 1)) & ~64'(size_bytes(op) - 1);
      else if (pick == 7)
        addr = 64'($urandom_range(0, 4095)) + 64'(MEM_BYTES);
      else
        addr = 64'($urandom_range(0, MEM_BYTES - 1));
      send_at(op, 5'($urandom_range(0, 31)), addr, {$urandom, $urandom});
    end
    drain();
  endtask

  initial
  begin
    int seed_dummy;
    seed_dummy    = $urandom(32'hc910);
    errors        = 0;
    checks        = 0;
    test_err_base = 0;
    cycles        = 0;
    rand_ready    = 1'b0;
    rst_n         = 1'b0;
    in_v          = 1'b0;
    in_op         = mem_pipe_pkg::e_op_ld;
    in_rd         = '0;
    in_rs1        = '0;
    in_imm        = '0;
    in_rs2        = '0;
    out_ready     = 1'b1;
    for (int i = 0; i < MEM_BYTES; i++)
      model_mem[i] = 8'h00;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    run_basic();
    finish_test("stores and loads of every size");
    run_misaligned();
    finish_test("misaligned accesses");
    run_out_of_range();
    finish_test("out-of-range accesses");
    run_stall();
    finish_test("back-pressure with loads");
    run_random();
    finish_test("random mixed traffic");

    $display("Summary: 5 tests, %0d results checked, %0d errors", checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* tests/mem_pipe_checker.sv */
/*
 * Concurrent assertions on the result port of the load/store pipe.
 * Bound into mem_pipe below; watches reset, the hold rule under
 * back-pressure and the zero data of fault reports.
 */

`timescale 1ns/1ps

module mem_pipe_checker (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 out_v_i,
  input  logic                                 out_ready_i,
  input  logic [mem_pipe_pkg::REG_ADDR_W-1:0]  out_rd_i,
  input  logic [mem_pipe_pkg::DWORD_W-1:0]     out_data_i,
  input  mem_pipe_pkg::mem_fault_e             out_fault_i
);

  // Result register empty right after reset
  a_idle_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !out_v_i)
    else $error("out_v_o high in the cycle after reset");

  // Stalled result keeps all its fields
  a_hold_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_v_i && !out_ready_i) |=>
      (out_v_i && $stable(out_rd_i) && $stable(out_data_i) && $stable(out_fault_i)))
    else $error("result changed while stalled by out_ready_i");

  a_fault_zero_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_v_i && out_fault_i != mem_pipe_pkg::e_fault_none) |-> (out_data_i == '0))
    else $error("fault report carries nonzero data");

endmodule

bind mem_pipe mem_pipe_checker i_checker (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .out_v_i     (out_v_o),
  .out_ready_i (out_ready_i),
  .out_rd_i    (out_rd_o),
  .out_data_i  (out_data_o),
  .out_fault_i (out_fault_o)
);

/* rtl/mem_pipe.sv */
/*
 * Top level of the load/store pipe.
 * Chains the address stage, the request queue and the data stage.
 * Instructions enter on a valid/ready port and leave in order as
 * load results or fault reports; stores produce no result.
 */

`timescale 1ns/1ps

module mem_pipe #(
  parameter int MEM_WORDS   = 64,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  input  logic                                 in_v_i,
  output logic                                 in_ready_o,
  input  mem_pipe_pkg::mem_op_e                in_op_i,
  input  logic [mem_pipe_pkg::REG_ADDR_W-1:0]  in_rd_i,
  input  logic [mem_pipe_pkg::DWORD_W-1:0]     in_rs1_i,
  input  logic [mem_pipe_pkg::DWORD_W-1:0]     in_imm_i,
  input  logic [mem_pipe_pkg::DWORD_W-1:0]     in_rs2_i,

  output logic                                 out_v_o,
  input  logic                                 out_ready_i,
  output logic [mem_pipe_pkg::REG_ADDR_W-1:0]  out_rd_o,
  output logic [mem_pipe_pkg::DWORD_W-1:0]     out_data_o,
  output mem_pipe_pkg::mem_fault_e             out_fault_o
);

  logic                                 req_v;
  mem_pipe_pkg::mem_op_e                req_op;
  logic [mem_pipe_pkg::REG_ADDR_W-1:0]  req_rd;
  logic [mem_pipe_pkg::EADDR_W-1:0]     req_addr;
  logic [mem_pipe_pkg::DWORD_W-1:0]     req_data;
  mem_pipe_pkg::mem_fault_e             req_fault;

  logic                                 head_v;
  mem_pipe_pkg::mem_op_e                head_op;
  logic [mem_pipe_pkg::REG_ADDR_W-1:0]  head_rd;
  logic [mem_pipe_pkg::EADDR_W-1:0]     head_addr;
  logic [mem_pipe_pkg::DWORD_W-1:0]     head_data;
  mem_pipe_pkg::mem_fault_e             head_fault;

  logic                                 pop;
  logic                                 credit;

  mem_agu #(
    .MEM_WORDS   (MEM_WORDS),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_agu (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_v_i      (in_v_i),
    .in_ready_o  (in_ready_o),
    .in_op_i     (in_op_i),
    .in_rd_i     (in_rd_i),
    .in_rs1_i    (in_rs1_i),
    .in_imm_i    (in_imm_i),
    .in_rs2_i    (in_rs2_i),
    .credit_i    (credit),
    .req_v_o     (req_v),
    .req_op_o    (req_op),
    .req_rd_o    (req_rd),
    .req_addr_o  (req_addr),
    .req_data_o  (req_data),
    .req_fault_o (req_fault)
  );

  mem_req_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_queue (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_v_i      (req_v),
    .req_op_i     (req_op),
    .req_rd_i     (req_rd),
    .req_addr_i   (req_addr),
    .req_data_i   (req_data),
    .req_fault_i  (req_fault),
    .head_v_o     (head_v),
    .head_op_o    (head_op),
    .head_rd_o    (head_rd),
    .head_addr_o  (head_addr),
    .head_data_o  (head_data),
    .head_fault_o (head_fault),
    .pop_i        (pop),
    .credit_o     (credit)
  );

  mem_data_stage #(
    .MEM_WORDS (MEM_WORDS)
  ) i_data (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .head_v_i     (head_v),
    .head_op_i    (head_op),
    .head_rd_i    (head_rd),
    .head_addr_i  (head_addr),
    .head_data_i  (head_data),
    .head_fault_i (head_fault),
    .pop_o        (pop),
    .out_v_o      (out_v_o),
    .out_ready_i  (out_ready_i),
    .out_rd_o     (out_rd_o),
    .out_data_o   (out_data_o),
    .out_fault_o  (out_fault_o)
  );

endmodule

/* rtl/mem_data_stage.sv */
/*
 * Data memory stage of the load/store pipe.
 * Takes the queue head when the result register is free, writes store
 * bytes into a little-endian word memory and returns loads sign- or
 * zero-extended. Faulting entries leave memory alone and produce a
 * result with the fault code and zero data.
 */

`timescale 1ns/1ps

module mem_data_stage #(
  parameter int MEM_WORDS = 64
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  input  logic                                 head_v_i,
  input  mem_pipe_pkg::mem_op_e                head_op_i,
  input  logic [mem_pipe_pkg::REG_ADDR_W-1:0]  head_rd_i,
  input  logic [mem_pipe_pkg::EADDR_W-1:0]     head_addr_i,
  input  logic [mem_pipe_pkg::DWORD_W-1:0]     head_data_i,
  input  mem_pipe_pkg::mem_fault_e             head_fault_i,
  output logic                                 pop_o,

  output logic                                 out_v_o,
  input  logic                                 out_ready_i,
  output logic [mem_pipe_pkg::REG_ADDR_W-1:0]  out_rd_o,
  output logic [mem_pipe_pkg::DWORD_W-1:0]     out_data_o,
  output mem_pipe_pkg::mem_fault_e             out_fault_o
);

  localparam int MEM_AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int DW     = mem_pipe_pkg::DWORD_W;

  logic [DW-1:0]     mem [MEM_WORDS];

  logic [MEM_AW-1:0] word_idx;
  logic [2:0]        byte_off;
  logic [1:0]        size;
  logic [7:0]        lane_mask;
  logic [7:0]        byte_en;
  logic [DW-1:0]     bit_mask;
  logic [DW-1:0]     cur_word;
  logic [DW-1:0]     st_shift;
  logic [DW-1:0]     merged;
  logic [DW-1:0]     ld_shift;
  logic [DW-1:0]     ld_ext;
  logic              is_fault;
  logic              is_store;
  logic              take;

  assign take     = head_v_i & (~out_v_o | out_ready_i);
  assign pop_o    = take;
  assign is_fault = (head_fault_i != mem_pipe_pkg::e_fault_none);
  assign is_store = mem_pipe_pkg::op_is_store(head_op_i);
  assign word_idx = head_addr_i[3 +: MEM_AW];
  assign byte_off = head_addr_i[2:0];

  always_comb
  begin
    size = mem_pipe_pkg::op_size(head_op_i);
    unique case (size)
      2'd0:    lane_mask = 8'h01;
      2'd1:    lane_mask = 8'h03;
      2'd2:    lane_mask = 8'h0f;
      default: lane_mask = 8'hff;
    endcase
    byte_en = lane_mask << byte_off;
    for (int lane = 0; lane < 8; lane++)
      bit_mask[lane*8 +: 8] = {8{byte_en[lane]}};

    cur_word = mem[word_idx];
    st_shift = head_data_i << {byte_off, 3'b000};
    merged   = (cur_word & ~bit_mask) | (st_shift & bit_mask);

    // Move the addressed lanes down, then extend
    ld_shift = cur_word >> {byte_off, 3'b000};
    unique case (size)
      2'd0: ld_ext = {{(DW-8){ld_shift[7] & ~mem_pipe_pkg::op_is_unsigned(head_op_i)}},
                      ld_shift[7:0]};
      2'd1: ld_ext = {{(DW-16){ld_shift[15] & ~mem_pipe_pkg::op_is_unsigned(head_op_i)}},
                      ld_shift[15:0]};
      2'd2: ld_ext = {{(DW-32){ld_shift[31] & ~mem_pipe_pkg::op_is_unsigned(head_op_i)}},
                      ld_shift[31:0]};
      default: ld_ext = ld_shift;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < MEM_WORDS; i++)
        mem[i] <= '0;
    end
    else if (take && is_store && !is_fault)
      mem[word_idx] <= merged;
  end

  // Result register; stores without a fault leave it empty
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      out_v_o <= 1'b0;
    else if (take)
      out_v_o <= is_fault | ~is_store;
    else if (out_ready_i)
      out_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (take)
    begin
      out_rd_o    <= head_rd_i;
      out_data_o  <= is_fault ? '0 : ld_ext;
      out_fault_o <= head_fault_i;
    end
  end

endmodule

/* rtl/mem_req_queue.sv */
/*
 * Request queue between the address stage and the data stage.
 * Circular buffer of QUEUE_DEPTH entries; the head is visible the cycle
 * after a write. Every pop returns one credit to the address stage in
 * the same cycle, so writes never find the queue full.
 */

`timescale 1ns/1ps

module mem_req_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  input  logic                                 req_v_i,
  input  mem_pipe_pkg::mem_op_e                req_op_i,
  input  logic [mem_pipe_pkg::REG_ADDR_W-1:0]  req_rd_i,
  input  logic [mem_pipe_pkg::EADDR_W-1:0]     req_addr_i,
  input  logic [mem_pipe_pkg::DWORD_W-1:0]     req_data_i,
  input  mem_pipe_pkg::mem_fault_e             req_fault_i,

  output logic                                 head_v_o,
  output mem_pipe_pkg::mem_op_e                head_op_o,
  output logic [mem_pipe_pkg::REG_ADDR_W-1:0]  head_rd_o,
  output logic [mem_pipe_pkg::EADDR_W-1:0]     head_addr_o,
  output logic [mem_pipe_pkg::DWORD_W-1:0]     head_data_o,
  output mem_pipe_pkg::mem_fault_e             head_fault_o,

  input  logic                                 pop_i,
  output logic                                 credit_o
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  mem_pipe_pkg::mem_op_e                op_q    [QUEUE_DEPTH];
  logic [mem_pipe_pkg::REG_ADDR_W-1:0]  rd_q    [QUEUE_DEPTH];
  logic [mem_pipe_pkg::EADDR_W-1:0]     addr_q  [QUEUE_DEPTH];
  logic [mem_pipe_pkg::DWORD_W-1:0]     data_q  [QUEUE_DEPTH];
  mem_pipe_pkg::mem_fault_e             fault_q [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  assign head_v_o     = (count != '0);
  assign do_pop       = pop_i & head_v_o;
  assign credit_o     = do_pop;

  assign head_op_o    = op_q[rd_ptr];
  assign head_rd_o    = rd_q[rd_ptr];
  assign head_addr_o  = addr_q[rd_ptr];
  assign head_data_o  = data_q[rd_ptr];
  assign head_fault_o = fault_q[rd_ptr];

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (req_v_i)
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (req_v_i && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !req_v_i)
        count <= count - 1'b1;
    end
  end

  // Entry storage
  always_ff @(posedge clk_i)
  begin
    if (req_v_i)
    begin
      op_q[wr_ptr]    <= req_op_i;
      rd_q[wr_ptr]    <= req_rd_i;
      addr_q[wr_ptr]  <= req_addr_i;
      data_q[wr_ptr]  <= req_data_i;
      fault_q[wr_ptr] <= req_fault_i;
    end
  end

endmodule

/* rtl/mem_agu.sv */
/*
 * Address stage of the load/store pipe.
 * Forms the effective address from rs1 and the immediate, decodes the
 * access size and flags misaligned and out-of-range accesses.
 * Owns the credit counter toward the request queue; in_ready_o is high
 * while a credit remains and the request is presented one cycle later.
 */

`timescale 1ns/1ps

module mem_agu #(
  parameter int MEM_WORDS   = 64,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,

  input  logic                                 in_v_i,
  output logic                                 in_ready_o,
  input  mem_pipe_pkg::mem_op_e                in_op_i,
  input  logic [mem_pipe_pkg::REG_ADDR_W-1:0]  in_rd_i,
  input  logic [mem_pipe_pkg::DWORD_W-1:0]     in_rs1_i,
  input  logic [mem_pipe_pkg::DWORD_W-1:0]     in_imm_i,
  input  logic [mem_pipe_pkg::DWORD_W-1:0]     in_rs2_i,

  input  logic                                 credit_i,

  output logic                                 req_v_o,
  output mem_pipe_pkg::mem_op_e                req_op_o,
  output logic [mem_pipe_pkg::REG_ADDR_W-1:0]  req_rd_o,
  output logic [mem_pipe_pkg::EADDR_W-1:0]     req_addr_o,
  output logic [mem_pipe_pkg::DWORD_W-1:0]     req_data_o,
  output mem_pipe_pkg::mem_fault_e             req_fault_o
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam logic [mem_pipe_pkg::EADDR_W-1:0] MEM_BYTES = MEM_WORDS * 8;

  logic [CNT_W-1:0]                    credits;
  logic                                accept;
  logic [mem_pipe_pkg::EADDR_W-1:0]    eaddr;
  logic [1:0]                          size;
  logic [2:0]                          align_mask;
  mem_pipe_pkg::mem_fault_e            fault;

  assign in_ready_o = (credits != '0);
  assign accept     = in_v_i & in_ready_o;

  always_comb
  begin
    eaddr      = in_rs1_i + in_imm_i;
    size       = mem_pipe_pkg::op_size(in_op_i);
    align_mask = 3'((4'd1 << size) - 4'd1);
    // Misalignment takes priority over the range check
    if ((eaddr[2:0] & align_mask) != 3'd0)
      fault = mem_pipe_pkg::e_fault_misaligned;
    else if (eaddr >= MEM_BYTES)
      fault = mem_pipe_pkg::e_fault_access;
    else
      fault = mem_pipe_pkg::e_fault_none;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      credits <= CNT_W'(QUEUE_DEPTH);
      req_v_o <= 1'b0;
    end
    else
    begin
      req_v_o <= accept;
      if (accept && !credit_i)
        credits <= credits - 1'b1;
      else if (credit_i && !accept)
        credits <= credits + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      req_op_o    <= in_op_i;
      req_rd_o    <= in_rd_i;
      req_addr_o  <= eaddr;
      req_data_o  <= in_rs2_i;
      req_fault_o <= fault;
    end
  end

endmodule

/* rtl/mem_pipe_pkg.sv */
/*
 * Shared definitions for the load/store pipe.
 * Holds the memory opcode and fault encodings, the datapath widths
 * and the small decode helpers used by the address and data stages.
 * Modules refer to everything here with mem_pipe_pkg:: scoped names.
 */

package mem_pipe_pkg;

  localparam int DWORD_W    = 64;
  localparam int REG_ADDR_W = 5;
  localparam int EADDR_W    = 64;

  typedef enum logic [3:0] {
    e_op_lb,
    e_op_lh,
    e_op_lw,
    e_op_ld,
    e_op_lbu,
    e_op_lhu,
    e_op_lwu,
    e_op_sb,
    e_op_sh,
    e_op_sw,
    e_op_sd
  } mem_op_e;

  typedef enum logic [1:0] {
    e_fault_none       = 2'd0,
    e_fault_misaligned = 2'd1,
    e_fault_access     = 2'd2
  } mem_fault_e;

  // log2 of the access size in bytes
  function automatic logic [1:0] op_size(mem_op_e op);
    unique case (op)
      e_op_lb, e_op_lbu, e_op_sb: return 2'd0;
      e_op_lh, e_op_lhu, e_op_sh: return 2'd1;
      e_op_lw, e_op_lwu, e_op_sw: return 2'd2;
      default:                    return 2'd3;
    endcase
  endfunction

  function automatic logic op_is_store(mem_op_e op);
    return (op == e_op_sb) || (op == e_op_sh) || (op == e_op_sw) || (op == e_op_sd);
  endfunction

  // Zero-extending loads
  function automatic logic op_is_unsigned(mem_op_e op);
    return (op == e_op_lbu) || (op == e_op_lhu) || (op == e_op_lwu);
  endfunction

endpackage
